/* Bender.yml */
package:
  name: cpu_pipeline

export_include_dirs:
  - include

sources:
  - hw/isa_pkg.sv
  - hw/core_pkg.sv
  - hw/alu.sv
  - hw/reg_file.sv
  - hw/inst_memory.sv
  - hw/data_memory.sv
  - hw/decode_unit.sv
  - hw/hazard_unit.sv
  - hw/cpu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
	input core_pkg::word_t a,
	input core_pkg::word_t b,
	input isa_pkg::alu_op_t op,
	output core_pkg::word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			isa_pkg::ALU_ADD: result = a + b;
			isa_pkg::ALU_SUB: result = a - b;
			isa_pkg::ALU_AND: result = a & b;
			isa_pkg::ALU_OR: result = a | b;
			isa_pkg::ALU_XOR: result = a ^ b;
			isa_pkg::ALU_NOR: result = ~(a | b);
			isa_pkg::ALU_SLT: begin
				// Signed compare, result is 0 or 1
				result = ($signed(a) < $signed(b)) ? core_pkg::word_t'(1) : '0;
			end
			default: result = '0;
		endcase
	end

	// Branch compare uses SUB, so zero means equal
	assign zero = (result == '0);

endmodule

/* hw/core_pkg.sv */
`include "cpu_config.svh"

package core_pkg;

	// Data and byte addresses
	typedef logic [`CPU_XLEN-1:0] word_t;

	typedef logic [31:0] instr_t;

	typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

	// Word addresses into the two memories
	typedef logic [`CPU_IMEM_AW-1:0] imem_addr_t;
	typedef logic [`CPU_DMEM_AW-1:0] dmem_addr_t;

endpackage

/* hw/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top (
	input logic clk,
	input logic rst,
	input logic imem_we,
	input core_pkg::imem_addr_t imem_addr,
	input core_pkg::instr_t imem_wdata,
	input core_pkg::dmem_addr_t dbg_addr,
	output core_pkg::word_t dbg_data
);

	core_pkg::word_t pc, pc_plus4, branch_target;
	core_pkg::instr_t fetch_instr;
	logic stall, flush, branch_taken;

	// IF/ID
	core_pkg::instr_t if_id_instr;
	core_pkg::word_t if_id_pc4;

	// Decode outputs
	isa_pkg::alu_op_t dec_alu_op;
	logic dec_alu_src_imm, dec_reg_write, dec_mem_read, dec_mem_write;
	logic dec_mem_to_reg, dec_branch_eq, dec_branch_ne, dec_re_rs, dec_re_rt;
	core_pkg::reg_idx_t dec_dest;
	core_pkg::word_t rf_rdata1, rf_rdata2;

	// ID/EX
	isa_pkg::alu_op_t id_ex_alu_op;
	logic id_ex_alu_src_imm, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
	logic id_ex_mem_to_reg, id_ex_branch_eq, id_ex_branch_ne;
	core_pkg::word_t id_ex_rdata1, id_ex_rdata2, id_ex_imm, id_ex_pc4;
	core_pkg::reg_idx_t id_ex_dest;
	core_pkg::word_t alu_b, alu_result;
	logic alu_zero;

	// EX/MEM
	logic ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;
	core_pkg::word_t ex_mem_alu_result, ex_mem_store_data, mem_rdata;
	core_pkg::reg_idx_t ex_mem_dest;

	// MEM/WB
	logic mem_wb_reg_write;
	core_pkg::word_t mem_wb_value;
	core_pkg::reg_idx_t mem_wb_dest;

	assign pc_plus4 = pc + core_pkg::word_t'(4);

	inst_memory inst_memory_inst (.clk(clk), .we(imem_we), .waddr(imem_addr),
		.wdata(imem_wdata), .raddr(core_pkg::imem_addr_t'(pc >> 2)), .rdata(fetch_instr));

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (flush)
			pc <= branch_target;
		else if (!stall)
			pc <= pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (rst || flush)
			if_id_instr <= '0; // Zero word is a nop
		else if (!stall)
			if_id_instr <= fetch_instr;
		if (!stall)
			if_id_pc4 <= pc_plus4;
	end

	decode_unit decode_unit_inst (.instr(if_id_instr), .alu_op(dec_alu_op),
		.alu_src_imm(dec_alu_src_imm), .reg_write(dec_reg_write), .mem_read(dec_mem_read),
		.mem_write(dec_mem_write), .mem_to_reg(dec_mem_to_reg), .branch_eq(dec_branch_eq),
		.branch_ne(dec_branch_ne), .re_rs(dec_re_rs), .re_rt(dec_re_rt), .dest(dec_dest));

	reg_file reg_file_inst (.clk(clk), .rst(rst), .we(mem_wb_reg_write), .waddr(mem_wb_dest),
		.wdata(mem_wb_value), .raddr1(if_id_instr[25:21]), .raddr2(if_id_instr[20:16]),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2));

	hazard_unit hazard_unit_inst (.rs(if_id_instr[25:21]), .rt(if_id_instr[20:16]),
		.re_rs(dec_re_rs), .re_rt(dec_re_rt), .dest_ex(id_ex_dest), .dest_mem(ex_mem_dest),
		.dest_wb(mem_wb_dest), .we_ex(id_ex_reg_write), .we_mem(ex_mem_reg_write),
		.we_wb(mem_wb_reg_write), .branch_taken(branch_taken), .stall(stall), .flush(flush));

	// Bubble on reset, stall or flush
	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin
			{id_ex_alu_src_imm, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write} <= '0;
			{id_ex_mem_to_reg, id_ex_branch_eq, id_ex_branch_ne} <= '0;
			id_ex_alu_op <= isa_pkg::ALU_ADD;
		end else begin
			{id_ex_alu_src_imm, id_ex_reg_write} <= {dec_alu_src_imm, dec_reg_write};
			{id_ex_mem_read, id_ex_mem_write} <= {dec_mem_read, dec_mem_write};
			{id_ex_mem_to_reg, id_ex_branch_eq} <= {dec_mem_to_reg, dec_branch_eq};
			id_ex_branch_ne <= dec_branch_ne;
			id_ex_alu_op <= dec_alu_op;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_rdata1 <= rf_rdata1;
		id_ex_rdata2 <= rf_rdata2;
		id_ex_imm <= core_pkg::word_t'($signed(if_id_instr[15:0])); // Sign extend
		id_ex_pc4 <= if_id_pc4;
		id_ex_dest <= dec_dest;
	end

	assign alu_b = id_ex_alu_src_imm ? id_ex_imm : id_ex_rdata2;

	alu alu_inst (.a(id_ex_rdata1), .b(alu_b), .op(id_ex_alu_op), .result(alu_result),
		.zero(alu_zero));

	assign branch_target = id_ex_pc4 + (id_ex_imm << 2);
	assign branch_taken = (id_ex_branch_eq && alu_zero) || (id_ex_branch_ne && !alu_zero);

	always_ff @(posedge clk) begin
		if (rst) begin
			{ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg} <= '0;
		end else begin
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
			ex_mem_mem_to_reg <= id_ex_mem_to_reg;
		end
		ex_mem_alu_result <= alu_result;
		ex_mem_store_data <= id_ex_rdata2; // rt value for sw
		ex_mem_dest <= id_ex_dest;
	end

	data_memory data_memory_inst (.clk(clk), .read(ex_mem_mem_read), .write(ex_mem_mem_write),
		.addr(core_pkg::dmem_addr_t'(ex_mem_alu_result >> 2)), .wdata(ex_mem_store_data),
		.rdata(mem_rdata), .dbg_addr(dbg_addr), .dbg_data(dbg_data));

	always_ff @(posedge clk) begin
		if (rst)
			mem_wb_reg_write <= 1'b0;
		else
			mem_wb_reg_write <= ex_mem_reg_write;
		mem_wb_value <= ex_mem_mem_to_reg ? mem_rdata : ex_mem_alu_result;
		mem_wb_dest <= ex_mem_dest;
	end

endmodule

/* hw/data_memory.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module data_memory (
	input logic clk,
	input logic read,
	input logic write,
	input core_pkg::dmem_addr_t addr,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rdata,
	input core_pkg::dmem_addr_t dbg_addr,
	output core_pkg::word_t dbg_data
);

	core_pkg::word_t mem [`CPU_DMEM_DEPTH] = '{default: '0};

	always_ff @(posedge clk) begin
		if (write)
			mem[addr] <= wdata;
	end

	// Load port returns zero when no load is active
	assign rdata = read ? mem[addr] : '0;

	assign dbg_data = mem[dbg_addr]; // Observation only
endmodule

/* hw/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit (
	input core_pkg::instr_t instr,
	output isa_pkg::alu_op_t alu_op,
	output logic alu_src_imm,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic branch_eq,
	output logic branch_ne,
	output logic re_rs,
	output logic re_rt,
	output core_pkg::reg_idx_t dest
);

	isa_pkg::opcode_t opcode;
	isa_pkg::funct_t funct;
	logic rtype_ok; // Known R-type function
	logic imm_alu;
	logic write_en;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		rtype_ok = 1'b1;
		case (opcode)
			isa_pkg::OP_RTYPE: begin
				case (funct)
					isa_pkg::FN_ADD: alu_op = isa_pkg::ALU_ADD;
					isa_pkg::FN_SUB: alu_op = isa_pkg::ALU_SUB;
					isa_pkg::FN_AND: alu_op = isa_pkg::ALU_AND;
					isa_pkg::FN_OR: alu_op = isa_pkg::ALU_OR;
					isa_pkg::FN_XOR: alu_op = isa_pkg::ALU_XOR;
					isa_pkg::FN_NOR: alu_op = isa_pkg::ALU_NOR;
					isa_pkg::FN_SLT: alu_op = isa_pkg::ALU_SLT;
					default: begin
						alu_op = isa_pkg::ALU_ADD;
						rtype_ok = 1'b0;
					end
				endcase
			end
			isa_pkg::OP_SLTI: alu_op = isa_pkg::ALU_SLT;
			isa_pkg::OP_ANDI: alu_op = isa_pkg::ALU_AND;
			isa_pkg::OP_ORI: alu_op = isa_pkg::ALU_OR;
			isa_pkg::OP_XORI: alu_op = isa_pkg::ALU_XOR;
			isa_pkg::OP_BEQ, isa_pkg::OP_BNE: alu_op = isa_pkg::ALU_SUB; // Compare by subtract
			default: alu_op = isa_pkg::ALU_ADD; // addi, lw, sw and unknown
		endcase
	end

	assign imm_alu = opcode inside {isa_pkg::OP_ADDI, isa_pkg::OP_SLTI, isa_pkg::OP_ANDI,
		isa_pkg::OP_ORI, isa_pkg::OP_XORI};

	assign mem_read = (opcode == isa_pkg::OP_LW);
	assign mem_write = (opcode == isa_pkg::OP_SW);
	assign mem_to_reg = mem_read;
	assign branch_eq = (opcode == isa_pkg::OP_BEQ);
	assign branch_ne = (opcode == isa_pkg::OP_BNE);
	assign alu_src_imm = imm_alu || mem_read || mem_write; // Address = rs + imm

	// Sources
	assign re_rs = (opcode == isa_pkg::OP_RTYPE) || alu_src_imm || branch_eq || branch_ne;
	assign re_rt = (opcode == isa_pkg::OP_RTYPE) || mem_write || branch_eq || branch_ne;

	// rd for R-type, rt for loads and immediates
	assign write_en = ((opcode == isa_pkg::OP_RTYPE) && rtype_ok) || imm_alu || mem_read;
	assign dest = !write_en ? '0 : (opcode == isa_pkg::OP_RTYPE) ? instr[15:11] : instr[20:16];
	assign reg_write = write_en && (dest != '0);

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
	input core_pkg::reg_idx_t rs,
	input core_pkg::reg_idx_t rt,
	input logic re_rs,
	input logic re_rt,
	input core_pkg::reg_idx_t dest_ex,
	input core_pkg::reg_idx_t dest_mem,
	input core_pkg::reg_idx_t dest_wb,
	input logic we_ex,
	input logic we_mem,
	input logic we_wb,
	input logic branch_taken,
	output logic stall,
	output logic flush
);

	logic rs_hit;
	logic rt_hit;

	// No bypass, so any pending write to a source blocks decode
	assign rs_hit = re_rs && ((we_ex && rs == dest_ex) ||
		(we_mem && rs == dest_mem) ||
		(we_wb && rs == dest_wb));

	assign rt_hit = re_rt && ((we_ex && rt == dest_ex) ||
		(we_mem && rt == dest_mem) ||
		(we_wb && rt == dest_wb));

	// A taken branch squashes the stalled instruction anyway
	assign stall = (rs_hit || rt_hit) && !branch_taken;
	assign flush = branch_taken;

endmodule

/* hw/inst_memory.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module inst_memory (
	input logic clk,
	input logic we,
	input core_pkg::imem_addr_t waddr,
	input core_pkg::instr_t wdata,
	input core_pkg::imem_addr_t raddr,
	output core_pkg::instr_t rdata
);

	// Empty words decode as a nop
	core_pkg::instr_t mem [`CPU_IMEM_DEPTH] = '{default: '0};

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata; // Program loader
	end

	assign rdata = mem[raddr];

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

	typedef logic [5:0] opcode_t; // Primary opcode, instr[31:26]
	typedef logic [5:0] funct_t; // R-type function, instr[5:0]
	typedef logic [3:0] alu_op_t;

	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ANDI = 6'b000001;
	localparam opcode_t OP_BEQ = 6'b000100;
	localparam opcode_t OP_BNE = 6'b000101;
	localparam opcode_t OP_ADDI = 6'b001000;
	localparam opcode_t OP_SLTI = 6'b001010;
	localparam opcode_t OP_ORI = 6'b001101;
	localparam opcode_t OP_XORI = 6'b001111;
	localparam opcode_t OP_LW = 6'b010111; // Nonstandard load opcode
	localparam opcode_t OP_SW = 6'b101011;

	localparam funct_t FN_ADD = 6'b100000;
	localparam funct_t FN_SUB = 6'b100010;
	localparam funct_t FN_AND = 6'b100100;
	localparam funct_t FN_OR = 6'b100101;
	localparam funct_t FN_XOR = 6'b100110;
	localparam funct_t FN_NOR = 6'b100111;
	localparam funct_t FN_SLT = 6'b101010;

	// Code 0010 is unused
	localparam alu_op_t ALU_ADD = 4'b0000;
	localparam alu_op_t ALU_SUB = 4'b0001;
	localparam alu_op_t ALU_AND = 4'b0011;
	localparam alu_op_t ALU_OR = 4'b0100;
	localparam alu_op_t ALU_SLT = 4'b0101;
	localparam alu_op_t ALU_NOR = 4'b0110;
	localparam alu_op_t ALU_XOR = 4'b0111;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input logic we,
	input core_pkg::reg_idx_t waddr,
	input core_pkg::word_t wdata,
	input core_pkg::reg_idx_t raddr1,
	input core_pkg::reg_idx_t raddr2,
	output core_pkg::word_t rdata1,
	output core_pkg::word_t rdata2
);

	core_pkg::word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// No write-through, a same-cycle read sees the old value
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

/* include/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath width
`define CPU_XLEN 32

// Register file geometry
`define CPU_REG_AW 5
`define CPU_NUM_REGS 32

// Instruction memory, word addressed
`define CPU_IMEM_AW 8
`define CPU_IMEM_DEPTH 256

// Data memory, word addressed
`define CPU_DMEM_AW 9
`define CPU_DMEM_DEPTH 512

`endif

/* src.f */
+incdir+include
+incdir+tests
hw/isa_pkg.sv
hw/core_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/inst_memory.sv
hw/data_memory.sv
hw/decode_unit.sv
hw/hazard_unit.sv
hw/cpu_top.sv
tests/cpu_tb.sv

/* tests/cpu_tb_programs.svh */
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

// Each program is a list of instructions and the data words it must leave behind.
// Programs use separate data regions, since data memory keeps its contents across resets.
task automatic build_programs();
	int p;

	// R-type operations, r1 = 12 and r2 = -6
	p = 0;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 12));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 2, 0, -6));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 3, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_SUB, 4, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_AND, 5, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_OR, 6, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_XOR, 7, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_NOR, 8, 1, 2));
	add_instr(p, encode_r(isa_pkg::FN_SLT, 9, 2, 1)); // -6 < 12 when signed
	for (int r = 3; r <= 9; r++)
		add_instr(p, encode_i(isa_pkg::OP_SW, r, 0, (r - 3) * 4));
	add_expect(p, 0, 32'd6);
	add_expect(p, 1, 32'd18);
	add_expect(p, 2, 32'd8);
	add_expect(p, 3, 32'hffff_fffe);
	add_expect(p, 4, 32'hffff_fff6);
	add_expect(p, 5, 32'd1);
	add_expect(p, 6, 32'd1);

	// Immediates, all sign extended
	p = 1;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 100));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 2, 1, -30));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 4, 0, -7));
	add_instr(p, encode_i(isa_pkg::OP_SLTI, 3, 4, 5));
	add_instr(p, encode_i(isa_pkg::OP_ANDI, 5, 4, -16));
	add_instr(p, encode_i(isa_pkg::OP_ORI, 6, 1, -256));
	add_instr(p, encode_i(isa_pkg::OP_XORI, 7, 1, 255));
	add_instr(p, encode_i(isa_pkg::OP_SW, 2, 0, 64));
	add_instr(p, encode_i(isa_pkg::OP_SW, 3, 0, 68));
	add_instr(p, encode_i(isa_pkg::OP_SW, 5, 0, 72));
	add_instr(p, encode_i(isa_pkg::OP_SW, 6, 0, 76));
	add_instr(p, encode_i(isa_pkg::OP_SW, 7, 0, 80));
	add_expect(p, 16, 32'd70);
	add_expect(p, 17, 32'd1);
	add_expect(p, 18, 32'hffff_fff0);
	add_expect(p, 19, 32'hffff_ff64);
	add_expect(p, 20, 32'd155);

	// Dependent chain, no independent work in between
	p = 2;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 1));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 1, 1, 1));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 1, 1, 1));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 1, 3));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 2, 1, 1));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 3, 2, 1));
	add_instr(p, encode_i(isa_pkg::OP_SW, 3, 0, 128));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 132));
	add_expect(p, 32, 32'd21);
	add_expect(p, 33, 32'd7);

	// Store, load back, use at once
	p = 3;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 3, 0, 192));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 1234));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 192));
	add_instr(p, encode_i(isa_pkg::OP_LW, 2, 0, 192));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 2, 2, 5));
	add_instr(p, encode_i(isa_pkg::OP_SW, 2, 0, 196));
	add_instr(p, encode_i(isa_pkg::OP_LW, 4, 3, 4)); // Base register plus offset
	add_instr(p, encode_i(isa_pkg::OP_SW, 4, 3, 8));
	add_expect(p, 48, 32'd1234);
	add_expect(p, 49, 32'd1239);
	add_expect(p, 50, 32'd1239);

	// Branches, offsets count words after the branch
	p = 4;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 9));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 2, 0, 9));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 3, 0, 77));
	add_instr(p, encode_i(isa_pkg::OP_SW, 3, 0, 256)); // Prior values
	add_instr(p, encode_i(isa_pkg::OP_SW, 3, 0, 260));
	add_instr(p, encode_i(isa_pkg::OP_BEQ, 2, 1, 2)); // Taken
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 256));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 260));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 264));
	add_instr(p, encode_i(isa_pkg::OP_BNE, 2, 1, 1)); // Not taken
	add_instr(p, encode_i(isa_pkg::OP_SW, 3, 0, 268));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 4, 0, 3));
	add_instr(p, encode_i(isa_pkg::OP_BNE, 1, 4, 1)); // Taken
	add_instr(p, encode_i(isa_pkg::OP_SW, 4, 0, 256));
	add_instr(p, encode_i(isa_pkg::OP_SW, 4, 0, 276));
	add_expect(p, 64, 32'd77);
	add_expect(p, 65, 32'd77);
	add_expect(p, 66, 32'd9);
	add_expect(p, 67, 32'd77);
	add_expect(p, 69, 32'd3);

	// Register 0 stays zero
	p = 5;
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 1, 0, 66));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 320));
	add_instr(p, encode_i(isa_pkg::OP_SW, 1, 0, 324));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 0, 0, 55));
	add_instr(p, encode_i(isa_pkg::OP_SW, 0, 0, 320));
	add_instr(p, encode_r(isa_pkg::FN_ADD, 0, 1, 1));
	add_instr(p, encode_i(isa_pkg::OP_SW, 0, 0, 324));
	add_instr(p, encode_i(isa_pkg::OP_ADDI, 2, 0, 1));
	add_instr(p, encode_i(isa_pkg::OP_SW, 2, 0, 328));
	add_expect(p, 80, 32'd0);
	add_expect(p, 81, 32'd0);
	add_expect(p, 82, 32'd1);
endtask

`endif

/* tests/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

	localparam int NUM_PROGS = 6;
	localparam int MAX_WORDS = 16; // Loader writes this many words, zero padded
	localparam int MAX_EXPECT = 8;
	localparam int RESET_CYCLES = 10;
	localparam int LOAD_CYCLES = (MAX_WORDS > RESET_CYCLES) ? MAX_WORDS : RESET_CYCLES;

	logic clk = 1'b0;
	logic rst;
	logic imem_we;
	core_pkg::imem_addr_t imem_addr;
	core_pkg::instr_t imem_wdata;
	core_pkg::dmem_addr_t dbg_addr;
	core_pkg::word_t dbg_data;

	core_pkg::instr_t prog_instr [NUM_PROGS][MAX_WORDS] = '{default: '0};
	int prog_len [NUM_PROGS] = '{default: 0};
	core_pkg::dmem_addr_t exp_addr [NUM_PROGS][MAX_EXPECT];
	core_pkg::word_t exp_value [NUM_PROGS][MAX_EXPECT];
	int exp_count [NUM_PROGS] = '{default: 0};

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	cpu_top cpu_top_inst (
		.clk(clk),
		.rst(rst),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data)
	);

	always #50 clk = ~clk;

	// R-type: op rd, rs, rt
	function automatic core_pkg::instr_t encode_r(isa_pkg::funct_t funct, int rd, int rs, int rt);
		return {isa_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	// I-type: op rt, rs, imm
	function automatic core_pkg::instr_t encode_i(isa_pkg::opcode_t op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic void add_instr(int p, core_pkg::instr_t instr);
		prog_instr[p][prog_len[p]] = instr;
		prog_len[p]++;
	endfunction

	function automatic void add_expect(int p, int word_addr, core_pkg::word_t value);
		exp_addr[p][exp_count[p]] = core_pkg::dmem_addr_t'(word_addr);
		exp_value[p][exp_count[p]] = value;
		exp_count[p]++;
	endfunction

	// Worst case is four cycles per instruction, plus pipeline fill
	function automatic int budget_cycles(int p);
		return 4 * prog_len[p] + 8;
	endfunction

	`include "cpu_tb_programs.svh"

	task automatic check_word(input string name, input core_pkg::word_t expected,
		input core_pkg::word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Loader runs while the core is held in reset
	task automatic load_program(input int p);
		@(posedge clk);
		rst <= 1'b1;
		for (int c = 0; c < LOAD_CYCLES; c++) begin
			if (c < MAX_WORDS) begin
				imem_we <= 1'b1;
				imem_addr <= core_pkg::imem_addr_t'(c);
				imem_wdata <= prog_instr[p][c];
			end else begin
				imem_we <= 1'b0;
			end
			@(posedge clk);
		end
		imem_we <= 1'b0;
		rst <= 1'b0;
	endtask

	task automatic check_program(input int p);
		for (int k = 0; k < exp_count[p]; k++) begin
			@(posedge clk);
			dbg_addr <= exp_addr[p][k];
			@(negedge clk); // Debug read is combinational
			check_word($sformatf("dbg_data[%0d]", exp_addr[p][k]), exp_value[p][k], dbg_data);
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		int total;
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		dbg_addr = '0;
		build_programs();
		total = 0;
		for (int p = 0; p < NUM_PROGS; p++)
			total += LOAD_CYCLES + 1 + budget_cycles(p) + exp_count[p] + 1;
		cycle_limit = total + 50;
		for (int p = 0; p < NUM_PROGS; p++) begin
			load_program(p);
			repeat (budget_cycles(p)) @(posedge clk);
			check_program(p);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
